//--- build.f
+incdir+.
fetch_pkg.sv
icache.sv
mshr_table.sv
fetch_ctrl.sv
fetch.sv
fetch_checker.sv
tb_fetch.sv

//--- fetch.sv
`timescale 1ns/1ps
`include "sys_consts.svh"

module fetch (
    input  logic                                       clock,
    input  logic                                       reset,

    input  fetch_pkg::addr_t                           target,
    input  logic                                       br_en,
    input  logic                                       ibuff_open,

    // memory side
    input  fetch_pkg::mem_tag_t                        mem_transaction_tag,
    input  logic                                       mem_transaction_started,
    input  fetch_pkg::mem_tag_t                        mem_data_tag,
    input  fetch_pkg::data_t                           mem_data,

    output logic                                       mem_en,
    output fetch_pkg::addr_t                           mem_addr,

    // instruction buffer side
    output fetch_pkg::inst_packet_t [`FETCH_WIDTH-1:0] out_insts,
    output logic [$clog2(`FETCH_WIDTH+1)-1:0]          num_insts
);
    import fetch_pkg::*;

    // lookup addresses from the controller
    addr_t rd_addr;
    addr_t pf_addr;

    // cache status
    logic  rd_hit;
    data_t rd_data;
    logic  pf_hit;

    // miss table status and fill
    logic  pend_a;
    logic  pend_b;
    logic  full;
    logic  fill_en;
    addr_t fill_addr;
    data_t fill_data;

    icache icache_i (
        .clock     (clock),
        .reset     (reset),
        .rd_addr   (rd_addr),
        .pf_addr   (pf_addr),
        .fill_en   (fill_en),
        .fill_addr (fill_addr),
        .fill_data (fill_data),
        .rd_hit    (rd_hit),
        .rd_data   (rd_data),
        .pf_hit    (pf_hit)
    );

    // a redirect flushes every outstanding miss
    mshr_table mshr_i (
        .clock                   (clock),
        .reset                   (reset),
        .flush                   (br_en),
        .mem_addr                (mem_addr),
        .mem_transaction_started (mem_transaction_started),
        .mem_transaction_tag     (mem_transaction_tag),
        .mem_data_tag            (mem_data_tag),
        .mem_data                (mem_data),
        .look_a                  (rd_addr),
        .look_b                  (pf_addr),
        .pend_a                  (pend_a),
        .pend_b                  (pend_b),
        .full                    (full),
        .fill_en                 (fill_en),
        .fill_addr               (fill_addr),
        .fill_data               (fill_data)
    );

    fetch_ctrl ctrl_i (
        .clock                   (clock),
        .reset                   (reset),
        .br_en                   (br_en),
        .target                  (target),
        .ibuff_open              (ibuff_open),
        .rd_hit                  (rd_hit),
        .rd_data                 (rd_data),
        .pf_hit                  (pf_hit),
        .pend_a                  (pend_a),
        .pend_b                  (pend_b),
        .full                    (full),
        .mem_transaction_started (mem_transaction_started),
        .rd_addr                 (rd_addr),
        .pf_addr                 (pf_addr),
        .mem_en                  (mem_en),
        .mem_addr                (mem_addr),
        .out_insts               (out_insts),
        .num_insts               (num_insts)
    );

endmodule

//--- fetch_checker.sv
`timescale 1ns/1ps
`include "sys_consts.svh"

module fetch_checker (
    input  logic                                       clock,
    input  logic                                       reset,

    // stimulus as the DUT sees it
    input  logic                                       br_en,
    input  fetch_pkg::addr_t                           target,
    input  logic                                       ibuff_open,

    // memory side
    input  logic                                       mem_en,
    input  fetch_pkg::addr_t                           mem_addr,
    input  logic                                       mem_transaction_started,
    input  fetch_pkg::mem_tag_t                        mem_transaction_tag,
    input  fetch_pkg::mem_tag_t                        mem_data_tag,

    // instruction buffer side
    input  fetch_pkg::inst_packet_t [`FETCH_WIDTH-1:0] out_insts,
    input  logic [$clog2(`FETCH_WIDTH+1)-1:0]          num_insts,

    // window that must stay cached while the hit loop runs
    input  logic                                       hit_check,
    input  fetch_pkg::addr_t                           hit_lo,
    input  fetch_pkg::addr_t                           hit_hi,

    output int                                         mismatch_count,
    output int                                         fault_count
);
    import fetch_pkg::*;

    localparam int FW   = `FETCH_WIDTH;
    localparam int TAGS = `NUM_MEM_TAGS;

    int n_mismatch = 0;
    int n_fault    = 0;

    // expected pc of the next emitted instruction
    addr_t           exp_pc;
    logic            prev_reset;
    logic            prev_br;
    logic            prev_open;

    // accepted, unflushed, not yet returned
    logic [TAGS-1:0] live;
    addr_t           live_addr [TAGS];

    assign mismatch_count = n_mismatch;
    assign fault_count    = n_fault;

    // instruction word stored at a byte address
    // swap the halves and scramble with an odd multiplier
    function automatic inst_t ref_inst(input addr_t addr);
        return {addr[15:0], addr[31:16]} ^ (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    always @(posedge clock) begin
        int n_live;
        if (reset) begin
            exp_pc     = '0;
            live       = '0;
            prev_reset = 1'b1;
            prev_br    = 1'b0;
            prev_open  = 1'b0;
        end else begin
            // outputs seen here come from the previous edge
            if (prev_reset && (num_insts != '0 || mem_en !== 1'b0)) begin
                n_mismatch++;
                $display("mismatch at time %0t: num_insts %0d mem_en %b after reset",
                         $time, num_insts, mem_en);
            end
            // nothing after a redirect edge or a closed buffer
            if ((prev_br || !prev_open) && num_insts != '0) begin
                n_mismatch++;
                $display("mismatch at time %0t: %0d instructions after %s", $time, num_insts,
                         prev_br ? "a redirect" : "a closed buffer");
            end
            // odd slot start gives a single instruction
            if (num_insts > 1 && out_insts[0].pc[2]) begin
                n_mismatch++;
                $display("mismatch at time %0t: packet from pc %h runs past its block",
                         $time, out_insts[0].pc);
            end
            for (int i = 0; i < FW; i++) begin
                if (out_insts[i].valid != (i < int'(num_insts))) begin
                    n_mismatch++;
                    $display("mismatch at time %0t: slot %0d valid %b with num_insts %0d",
                             $time, i, out_insts[i].valid, num_insts);
                end
                if (out_insts[i].valid) begin
                    if (out_insts[i].pc != exp_pc) begin
                        n_mismatch++;
                        $display("mismatch at time %0t: slot %0d pc %h, expected %h",
                                 $time, i, out_insts[i].pc, exp_pc);
                    end
                    if (out_insts[i].inst != ref_inst(exp_pc)) begin
                        n_mismatch++;
                        $display("mismatch at time %0t: inst at %h is %h, expected %h",
                                 $time, exp_pc, out_insts[i].inst, ref_inst(exp_pc));
                    end
                    exp_pc = exp_pc + 32'd4;
                end
            end

            // request discipline
            if (mem_en && mem_addr[2:0] != 3'b000) begin
                n_mismatch++;
                $display("mismatch at time %0t: mem_addr %h not block aligned", $time, mem_addr);
            end
            n_live = 0;
            for (int t = 1; t < TAGS; t++) begin
                if (live[t]) begin
                    n_live++;
                    if (mem_en && live_addr[t][31:3] == mem_addr[31:3]) begin
                        n_fault++;
                        $display("error at time %0t: block %h requested again while tag %0d is out",
                                 $time, mem_addr, t);
                    end
                end
            end
            if (n_live == TAGS - 1 && mem_en) begin
                n_fault++;
                $display("error at time %0t: request raised with every tag outstanding", $time);
            end
            if (hit_check && mem_transaction_started && mem_addr >= hit_lo && mem_addr < hit_hi) begin
                n_fault++;
                $display("error at time %0t: memory request for cached block %h", $time, mem_addr);
            end

            // bookkeeping for this edge, redirect flushes all
            if (br_en) begin
                live   = '0;
                exp_pc = target;
            end else begin
                if (mem_data_tag != '0) begin
                    live[mem_data_tag] = 1'b0;
                end
                if (mem_transaction_started) begin
                    live[mem_transaction_tag]      = 1'b1;
                    live_addr[mem_transaction_tag] = mem_addr;
                end
            end
            prev_reset = 1'b0;
            prev_br    = br_en;
            prev_open  = ibuff_open;
        end
    end

endmodule

//--- fetch_ctrl.sv
`timescale 1ns/1ps
`include "sys_consts.svh"

module fetch_ctrl (
    input  logic                                       clock,
    input  logic                                       reset,

    // redirect
    input  logic                                       br_en,
    input  fetch_pkg::addr_t                           target,
    input  logic                                       ibuff_open,

    // cache and miss table status
    input  logic                                       rd_hit,
    input  fetch_pkg::data_t                           rd_data,
    input  logic                                       pf_hit,
    input  logic                                       pend_a,
    input  logic                                       pend_b,
    input  logic                                       full,
    input  logic                                       mem_transaction_started,

    // lookup addresses
    output fetch_pkg::addr_t                           rd_addr,
    output fetch_pkg::addr_t                           pf_addr,

    // memory request
    output logic                                       mem_en,
    output fetch_pkg::addr_t                           mem_addr,

    // toward the instruction buffer
    output fetch_pkg::inst_packet_t [`FETCH_WIDTH-1:0] out_insts,
    output logic [$clog2(`FETCH_WIDTH+1)-1:0]          num_insts
);
    import fetch_pkg::*;

    localparam int    FW          = `FETCH_WIDTH;
    localparam int    CNT_BITS    = $clog2(`FETCH_WIDTH + 1);
    localparam int    WORD_BITS   = $bits(inst_t);
    localparam int    WORDS       = $bits(data_t) / WORD_BITS;
    localparam int    OFFSET_BITS = $clog2($bits(data_t) / 8);
    localparam addr_t BLOCK_BYTES = addr_t'($bits(data_t) / 8);

    fetch_state_e state;
    fetch_state_e next_state;
    addr_t        pc;

    logic                     emit;
    inst_packet_t [FW-1:0]    next_out_insts;
    logic [CNT_BITS-1:0]      next_num_insts;

    logic req_valid;
    logic need_a;
    logic need_b;
    logic req_stale;

    // block under the pc and the one after it
    assign rd_addr = pc & ~(BLOCK_BYTES - addr_t'(1));
    assign pf_addr = rd_addr + BLOCK_BYTES;

    // hand out the block only while streaming and when the buffer can take it
    assign emit = (state == fetch_stream) && rd_hit && ibuff_open;

    // miss tracking
    always_comb begin
        next_state = state;
        case (state)
            fetch_stream: begin
                if (!rd_hit) begin
                    next_state = fetch_miss;
                end
            end
            fetch_miss: begin
                // fill landed so stream again
                if (rd_hit) begin
                    next_state = fetch_stream;
                end
            end
            default: next_state = fetch_stream;
        endcase
    end

    // packet assembly
    // emission starts at the pc slot and stops at the block end
    always_comb begin
        int lane;
        next_out_insts = '0;
        next_num_insts = '0;
        for (int i = 0; i < FW; i++) begin
            lane = int'(pc[OFFSET_BITS-1:2]) + i;
            if (emit && lane < WORDS) begin
                next_out_insts[i].valid = 1'b1;
                next_out_insts[i].pc    = rd_addr + addr_t'(lane * 4);
                next_out_insts[i].inst  = rd_data[lane*WORD_BITS +: WORD_BITS];
                next_num_insts          = next_num_insts + 1'b1;
            end
        end
    end

    // blocks that still need a memory request
    assign need_a = !rd_hit && !pend_a;
    assign need_b = !pf_hit && !pend_b;

    // held request no longer useful
    // its block hit, went pending, or fell out of the window
    always_comb begin
        if (mem_addr == rd_addr) begin
            req_stale = rd_hit || pend_a;
        end else if (mem_addr == pf_addr) begin
            req_stale = pf_hit || pend_b;
        end else begin
            req_stale = 1'b1;
        end
    end

    // no request while every tag is out
    assign mem_en = req_valid && !full;

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= fetch_stream;
            pc        <= '0;
            out_insts <= '0;
            num_insts <= '0;
            req_valid <= 1'b0;
            mem_addr  <= '0;
        end else if (br_en) begin
            // redirect leaves the cache untouched
            state     <= fetch_stream;
            pc        <= target;
            out_insts <= '0;
            num_insts <= '0;
            req_valid <= 1'b0;
        end else begin
            state     <= next_state;
            out_insts <= next_out_insts;
            num_insts <= next_num_insts;
            // skip past what went out
            if (emit) begin
                pc <= pc + (addr_t'(next_num_insts) << 2);
            end
            // request register
            // mem_addr holds until the memory takes it
            if (req_valid) begin
                if (mem_transaction_started || req_stale) begin
                    req_valid <= 1'b0;
                end
            end else if (need_a) begin
                req_valid <= 1'b1;
                mem_addr  <= rd_addr;
            end else if (need_b) begin
                req_valid <= 1'b1;
                mem_addr  <= pf_addr;
            end
        end
    end

    // packet count fits the fetch width
    a_num_bound: assert property (
        @(posedge clock) disable iff (reset)
        num_insts <= CNT_BITS'(FW)
    ) else $error("fetch_ctrl: num_insts %0d above fetch width", num_insts);

endmodule

//--- fetch_pkg.sv
`include "sys_consts.svh"

package fetch_pkg;

    // byte address
    typedef logic [`ADDR_BITS-1:0] addr_t;

    // one memory block, low word is the lower address
    typedef logic [63:0] data_t;

    // single instruction word
    typedef logic [31:0] inst_t;

    // memory transaction tag, 0 is unused
    typedef logic [$clog2(`NUM_MEM_TAGS)-1:0] mem_tag_t;

    // one slot toward the instruction buffer
    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_t inst;
    } inst_packet_t;

    // controller state
    // fetch_stream while the demand block hits, fetch_miss while waiting on a fill
    typedef enum logic {
        fetch_stream,
        fetch_miss
    } fetch_state_e;

endpackage

//--- icache.sv
`timescale 1ns/1ps
`include "sys_consts.svh"

module icache (
    input  logic             clock,
    input  logic             reset,

    // demand read, the block under the pc
    input  fetch_pkg::addr_t rd_addr,
    // prefetch probe, the block after it
    input  fetch_pkg::addr_t pf_addr,

    // fill from the miss table
    input  logic             fill_en,
    input  fetch_pkg::addr_t fill_addr,
    input  fetch_pkg::data_t fill_data,

    output logic             rd_hit,
    output fetch_pkg::data_t rd_data,
    output logic             pf_hit
);
    import fetch_pkg::*;

    // address split: | tag | index | block offset |
    localparam int OFFSET_BITS = $clog2($bits(data_t) / 8);
    localparam int INDEX_BITS  = $clog2(`ICACHE_LINES);
    localparam int TAG_BITS    = `ADDR_BITS - INDEX_BITS - OFFSET_BITS;

    logic [`ICACHE_LINES-1:0] line_valid;
    logic [TAG_BITS-1:0]      line_tag  [`ICACHE_LINES];
    data_t                    line_data [`ICACHE_LINES];

    logic [INDEX_BITS-1:0] rd_idx;
    logic [INDEX_BITS-1:0] pf_idx;
    logic [INDEX_BITS-1:0] fill_idx;
    logic [TAG_BITS-1:0]   rd_tag;
    logic [TAG_BITS-1:0]   pf_tag;
    logic [TAG_BITS-1:0]   fill_tag;

    // index and tag fields for each port
    assign rd_idx   = rd_addr[OFFSET_BITS +: INDEX_BITS];
    assign pf_idx   = pf_addr[OFFSET_BITS +: INDEX_BITS];
    assign fill_idx = fill_addr[OFFSET_BITS +: INDEX_BITS];

    assign rd_tag   = rd_addr[`ADDR_BITS-1 -: TAG_BITS];
    assign pf_tag   = pf_addr[`ADDR_BITS-1 -: TAG_BITS];
    assign fill_tag = fill_addr[`ADDR_BITS-1 -: TAG_BITS];

    // demand port, combinational lookup
    assign rd_hit  = line_valid[rd_idx] && (line_tag[rd_idx] == rd_tag);
    assign rd_data = line_data[rd_idx];

    // prefetch port only needs presence
    assign pf_hit  = line_valid[pf_idx] && (line_tag[pf_idx] == pf_tag);

    // valid bits, cleared only by reset
    // a redirect keeps the contents
    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (fill_en) begin
            line_valid[fill_idx] <= 1'b1;
        end
    end

    // tag and block storage
    // a fill simply overwrites whatever sat in the line
    always_ff @(posedge clock) begin
        if (fill_en) begin
            line_tag[fill_idx]  <= fill_tag;
            line_data[fill_idx] <= fill_data;
        end
    end

    // fills come from mem_addr, which the controller keeps block aligned
    a_fill_aligned: assert property (
        @(posedge clock) disable iff (reset)
        fill_en |-> (fill_addr[OFFSET_BITS-1:0] == '0)
    ) else $error("icache: unaligned fill address %h", fill_addr);

endmodule

//--- mshr_table.sv
`timescale 1ns/1ps
`include "sys_consts.svh"

module mshr_table (
    input  logic                clock,
    input  logic                reset,
    // redirect, forget every outstanding miss
    input  logic                flush,

    // request side
    input  fetch_pkg::addr_t    mem_addr,
    input  logic                mem_transaction_started,
    input  fetch_pkg::mem_tag_t mem_transaction_tag,

    // return side
    input  fetch_pkg::mem_tag_t mem_data_tag,
    input  fetch_pkg::data_t    mem_data,

    // pending lookups for the demand and prefetch blocks
    input  fetch_pkg::addr_t    look_a,
    input  fetch_pkg::addr_t    look_b,
    output logic                pend_a,
    output logic                pend_b,

    // every usable tag in flight
    output logic                full,

    // fill toward the cache
    output logic                fill_en,
    output fetch_pkg::addr_t    fill_addr,
    output fetch_pkg::data_t    fill_data
);
    import fetch_pkg::*;

    localparam int TAGS        = `NUM_MEM_TAGS;
    localparam int OFFSET_BITS = $clog2($bits(data_t) / 8);

    // one entry per tag, entry 0 stays empty
    addr_t            entry_addr [TAGS];
    logic [TAGS-1:0]  entry_valid;

    // tags 1..TAGS-1 all busy
    assign full = &entry_valid[TAGS-1:1];

    // returned data only counts under a live tag
    // data under a flushed tag finds its entry invalid and is dropped
    assign fill_en   = (mem_data_tag != '0) && entry_valid[mem_data_tag];
    assign fill_addr = entry_addr[mem_data_tag];
    assign fill_data = mem_data;

    // block compare of both lookups against every live entry
    always_comb begin
        pend_a = 1'b0;
        pend_b = 1'b0;
        for (int t = 1; t < TAGS; t++) begin
            if (entry_valid[t] &&
                entry_addr[t][`ADDR_BITS-1:OFFSET_BITS] == look_a[`ADDR_BITS-1:OFFSET_BITS]) begin
                pend_a = 1'b1;
            end
            if (entry_valid[t] &&
                entry_addr[t][`ADDR_BITS-1:OFFSET_BITS] == look_b[`ADDR_BITS-1:OFFSET_BITS]) begin
                pend_b = 1'b1;
            end
        end
    end

    // valid bits
    // retire first, then allocate
    // flush wins over an acceptance in the same cycle
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            entry_valid <= '0;
        end else begin
            if (fill_en) begin
                entry_valid[mem_data_tag] <= 1'b0;
            end
            if (mem_transaction_started) begin
                entry_valid[mem_transaction_tag] <= 1'b1;
            end
        end
    end

    // address recorded under the tag the memory handed back
    always_ff @(posedge clock) begin
        if (mem_transaction_started) begin
            entry_addr[mem_transaction_tag] <= mem_addr;
        end
    end

    // memory must hand out a tag that is free on our side too
    a_alloc_free: assert property (
        @(posedge clock) disable iff (reset)
        mem_transaction_started |-> !entry_valid[mem_transaction_tag]
    ) else $error("mshr: tag %0d allocated while outstanding", mem_transaction_tag);

    // tag 0 is reserved
    a_alloc_tag: assert property (
        @(posedge clock) disable iff (reset)
        mem_transaction_started |-> (mem_transaction_tag != '0)
    ) else $error("mshr: transaction started with tag 0");

endmodule

//--- sys_consts.svh
`ifndef SYS_CONSTS_SVH
`define SYS_CONSTS_SVH

// instructions handed to the instruction buffer per cycle
`define FETCH_WIDTH 2

// memory transaction tag space
// tag 0 is reserved and means no transaction
`define NUM_MEM_TAGS 16

// direct mapped, one 64-bit block per line
`define ICACHE_LINES 32

// byte address width
`define ADDR_BITS 32

`endif

//--- tb_fetch.sv
`timescale 1ns/1ps
`include "sys_consts.svh"

module tb_fetch;
    import fetch_pkg::*;

    localparam int FW             = `FETCH_WIDTH;
    localparam int TAGS           = `NUM_MEM_TAGS;
    // nominal length of all phases
    localparam int STIM_CYCLES    = 1700;
    localparam int TIMEOUT_CYCLES = 20 * STIM_CYCLES;
    // hit loop window, eight blocks
    localparam addr_t LOOP_BASE   = 32'h0000_0400;
    localparam int    LOOP_BYTES  = 64;
    localparam addr_t LOOP_LAST   = LOOP_BASE + addr_t'(LOOP_BYTES - 4);

    logic         clock;
    logic         reset;
    addr_t        target                  = '0;
    logic         br_en                   = 1'b0;
    logic         ibuff_open              = 1'b1;
    mem_tag_t     mem_transaction_tag     = '0;
    logic         mem_transaction_started = 1'b0;
    mem_tag_t     mem_data_tag            = '0;
    data_t        mem_data                = '0;
    logic         mem_en;
    addr_t        mem_addr;
    inst_packet_t [FW-1:0] out_insts;
    logic [$clog2(FW+1)-1:0] num_insts;
    logic         hit_check               = 1'b0;
    int           mismatch_count;
    int           fault_count;

    // sequence to driver hand-off
    integer seed         = 32'h59d;
    int     cycle        = 0;
    logic   stall_mode   = 1'b0;
    logic   hold_returns = 1'b0;
    int     branch_seq   = 0;
    int     branch_done  = 0;
    addr_t  branch_addr  = '0;
    int     seq_faults   = 0;
    bit     ok;

    // memory model state, per tag
    logic [TAGS-1:0] busy        = '0;
    addr_t           tag_addr  [TAGS];
    int              ret_cycle [TAGS];
    int              accept_wait = -1;

    fetch fetch_i (
        .clock                   (clock),
        .reset                   (reset),
        .target                  (target),
        .br_en                   (br_en),
        .ibuff_open              (ibuff_open),
        .mem_transaction_tag     (mem_transaction_tag),
        .mem_transaction_started (mem_transaction_started),
        .mem_data_tag            (mem_data_tag),
        .mem_data                (mem_data),
        .mem_en                  (mem_en),
        .mem_addr                (mem_addr),
        .out_insts               (out_insts),
        .num_insts               (num_insts)
    );

    fetch_checker check_i (
        .clock                   (clock),
        .reset                   (reset),
        .br_en                   (br_en),
        .target                  (target),
        .ibuff_open              (ibuff_open),
        .mem_en                  (mem_en),
        .mem_addr                (mem_addr),
        .mem_transaction_started (mem_transaction_started),
        .mem_transaction_tag     (mem_transaction_tag),
        .mem_data_tag            (mem_data_tag),
        .out_insts               (out_insts),
        .num_insts               (num_insts),
        .hit_check               (hit_check),
        .hit_lo                  (LOOP_BASE),
        .hit_hi                  (LOOP_BASE + addr_t'(LOOP_BYTES)),
        .mismatch_count          (mismatch_count),
        .fault_count             (fault_count)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    task automatic run_cycles(input int n);
        repeat (n) @(posedge clock);
    endtask

    // handed to the driver, returns at the edge that samples br_en
    task automatic branch_to(input addr_t addr);
        branch_addr = addr;
        branch_seq++;
        while (branch_done != branch_seq) begin
            @(posedge clock);
        end
    endtask

    // wait until the packet for last_pc goes out
    task automatic wait_reach(input addr_t last_pc, input int limit, output bit reached);
        int waited;
        reached = 1'b0;
        waited  = 0;
        while (!reached && waited < limit) begin
            @(posedge clock);
            waited++;
            for (int i = 0; i < FW; i++) begin
                if (out_insts[i].valid && out_insts[i].pc == last_pc) begin
                    reached = 1'b1;
                end
            end
        end
    endtask

    task automatic report_counts();
        $display("error counts: %0d mismatches, %0d protocol faults, %0d stalled waits",
                 mismatch_count, fault_count, seq_faults);
    endtask

    // all DUT inputs change here, on the falling edge
    always @(negedge clock) begin
        int free_tags [$];
        int ret_tag;
        int pick;
        mem_transaction_started = 1'b0;
        mem_transaction_tag     = '0;
        mem_data_tag            = '0;
        mem_data                = '0;
        br_en                   = 1'b0;
        if (branch_done != branch_seq) begin
            br_en       = 1'b1;
            target      = branch_addr;
            branch_done = branch_seq;
        end
        // buffer open three cycles in four while stalling
        ibuff_open = stall_mode ? (($unsigned($random(seed)) % 4) != 0) : 1'b1;
        // one return per cycle, lowest due tag
        ret_tag = 0;
        if (!hold_returns) begin
            for (int t = TAGS - 1; t >= 1; t--) begin
                if (busy[t] && cycle >= ret_cycle[t]) begin
                    ret_tag = t;
                end
            end
        end
        if (ret_tag != 0) begin
            mem_data_tag = mem_tag_t'(ret_tag);
            mem_data     = {check_i.ref_inst(tag_addr[ret_tag] + 32'd4),
                            check_i.ref_inst(tag_addr[ret_tag])};
        end
        // accept after 0 to 3 cycles, returning tag still counts as busy
        if (mem_en !== 1'b1) begin
            accept_wait = -1;
        end else begin
            if (accept_wait < 0) begin
                accept_wait = $unsigned($random(seed)) % 4;
            end
            if (accept_wait > 0) begin
                accept_wait--;
            end else begin
                for (int t = 1; t < TAGS; t++) begin
                    if (!busy[t]) begin
                        free_tags.push_back(t);
                    end
                end
                if (free_tags.size() > 0) begin
                    pick                    = free_tags[$unsigned($random(seed)) % free_tags.size()];
                    mem_transaction_started = 1'b1;
                    mem_transaction_tag     = mem_tag_t'(pick);
                    busy[pick]              = 1'b1;
                    tag_addr[pick]          = mem_addr;
                    ret_cycle[pick]         = cycle + 3 + int'($unsigned($random(seed)) % 18);
                    accept_wait             = -1;
                end
                free_tags.delete();
            end
        end
        if (ret_tag != 0) begin
            busy[ret_tag] = 1'b0;
        end
    end

    always @(negedge clock) begin
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            report_counts();
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(negedge clock);
        reset = 1'b0;
        @(posedge clock);

        // straight stream from address 0
        run_cycles(300);

        // random back-pressure from the buffer
        stall_mode = 1'b1;
        run_cycles(300);

        // redirects to random words, odd slots too
        repeat (16) begin
            branch_to(addr_t'($unsigned($random(seed)) & 32'h0000_0ffc));
            run_cycles(5 + int'($unsigned($random(seed)) % 35));
        end
        stall_mode = 1'b0;

        // returns held while redirects use up tags
        // flushed data comes back later and must be dropped
        hold_returns = 1'b1;
        for (int k = 0; k < 12; k++) begin
            branch_to(32'h0000_2000 + addr_t'(k * 'h44));
            run_cycles(8);
        end
        run_cycles(40);
        hold_returns = 1'b0;
        run_cycles(120);

        // first pass fills the loop window
        branch_to(LOOP_BASE);
        wait_reach(LOOP_LAST, 2000, ok);
        if (!ok) begin
            seq_faults++;
            $display("hit loop: first pass never reached pc %h", LOOP_LAST);
        end
        branch_to(LOOP_BASE);
        @(negedge clock);
        hit_check = 1'b1;
        // later passes run from the cache alone
        repeat (4) begin
            wait_reach(LOOP_LAST, 100, ok);
            if (!ok) begin
                seq_faults++;
                $display("hit loop: pc %h not reached within 100 cycles", LOOP_LAST);
            end
            branch_to(LOOP_BASE);
        end
        @(negedge clock);
        hit_check = 1'b0;
        run_cycles(40);

        @(negedge clock);
        report_counts();
        if (mismatch_count + fault_count + seq_faults == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
